// ==== source/id_pkg.sv ====
`default_nettype none

package id_pkg;

	// ####################################################################
	// Widths and fixed register numbers

	localparam int unsigned word_w     = 32;
	localparam int unsigned reg_addr_w = 5;
	localparam int unsigned alu_op_w   = 8;
	localparam int unsigned alu_sel_w  = 3;

	typedef logic [word_w-1:0]     word_t;
	typedef logic [reg_addr_w-1:0] reg_addr_t;

	localparam reg_addr_t zero_reg_c = 5'd0;
	localparam reg_addr_t link_reg_c = 5'd31;

	// ####################################################################
	// Encodings

	// Primary opcode, instruction bits 31..26.
	typedef enum logic [5:0] {
		op_special = 6'b000000,
		op_j       = 6'b000010,
		op_jal     = 6'b000011,
		op_beq     = 6'b000100,
		op_bne     = 6'b000101,
		op_bgtz    = 6'b000111,
		op_addi    = 6'b001000,
		op_addiu   = 6'b001001,
		op_slti    = 6'b001010,
		op_sltiu   = 6'b001011,
		op_andi    = 6'b001100,
		op_ori     = 6'b001101,
		op_lw      = 6'b100011,
		op_sw      = 6'b101011
	} opcode_e;

	// Function field of the special opcode, bits 5..0.
	typedef enum logic [5:0] {
		fn_sll  = 6'b000000,
		fn_srl  = 6'b000010,
		fn_sra  = 6'b000011,
		fn_sllv = 6'b000100,
		fn_jr   = 6'b001000,
		fn_movz = 6'b001010,
		fn_movn = 6'b001011,
		fn_add  = 6'b100000,
		fn_addu = 6'b100001,
		fn_sub  = 6'b100010,
		fn_subu = 6'b100011,
		fn_and  = 6'b100100,
		fn_or   = 6'b100101,
		fn_nor  = 6'b100111,
		fn_slt  = 6'b101010,
		fn_sltu = 6'b101011
	} funct_e;

	typedef enum logic [alu_op_w-1:0] {
		exe_nop_op   = 8'b0000_0000,
		exe_srl_op   = 8'b0000_0010,
		exe_sra_op   = 8'b0000_0011,
		exe_jr_op    = 8'b0000_1000,
		exe_movz_op  = 8'b0000_1010,
		exe_movn_op  = 8'b0000_1011,
		exe_add_op   = 8'b0010_0000,
		exe_addu_op  = 8'b0010_0001,
		exe_sub_op   = 8'b0010_0010,
		exe_subu_op  = 8'b0010_0011,
		exe_and_op   = 8'b0010_0100,
		exe_or_op    = 8'b0010_0101,
		exe_nor_op   = 8'b0010_0111,
		exe_slt_op   = 8'b0010_1010,
		exe_sltu_op  = 8'b0010_1011,
		exe_j_op     = 8'b0100_1111,
		exe_jal_op   = 8'b0101_0000,
		exe_beq_op   = 8'b0101_0001,
		exe_bne_op   = 8'b0101_0010,
		exe_bgtz_op  = 8'b0101_0100,
		exe_addi_op  = 8'b0101_0101,
		exe_addiu_op = 8'b0101_0110,
		exe_sll_op   = 8'b0111_1100,
		exe_lw_op    = 8'b1110_0011,
		exe_sw_op    = 8'b1110_1011
	} alu_op_e;

	typedef enum logic [alu_sel_w-1:0] {
		res_nop         = 3'b000,
		res_logic       = 3'b001,
		res_shift       = 3'b010,
		res_move        = 3'b011,
		res_arith       = 3'b100,
		res_jump_branch = 3'b110,
		res_load_store  = 3'b111
	} alu_sel_e;

	typedef enum logic [2:0] {
		br_none,
		br_j,
		br_jal,
		br_jr,
		br_beq,
		br_bne,
		br_bgtz
	} branch_kind_e;

	// ####################################################################
	// Bundles

	// For j and jal, imm carries the 26-bit index. For branches it is the offset.
	typedef struct packed {
		alu_op_e      alu_op;
		alu_sel_e     alu_sel;
		reg_addr_t    wd;
		logic         wreg;
		logic         rd_a;
		logic         rd_b;
		reg_addr_t    addr_a;
		reg_addr_t    addr_b;
		word_t        imm;
		branch_kind_e branch_kind;
	} decode_t;

	typedef struct packed {
		logic      re_a;
		logic      re_b;
		reg_addr_t addr_a;
		reg_addr_t addr_b;
	} rf_req_t;

	typedef struct packed {
		logic      wreg;
		reg_addr_t wd;
		word_t     wdata;
	} bypass_t;

	typedef struct packed {
		logic  taken;
		word_t target;
		word_t link_addr;
	} branch_t;

	typedef struct packed {
		alu_op_e   alu_op;
		alu_sel_e  alu_sel;
		word_t     op_a;
		word_t     op_b;
		reg_addr_t wd;
		logic      wreg;
		word_t     link_addr;
		logic      in_delay_slot;
	} id_ex_t;

	localparam id_ex_t id_ex_bubble_c = '{
		alu_op:        exe_nop_op,
		alu_sel:       res_nop,
		op_a:          '0,
		op_b:          '0,
		wd:            zero_reg_c,
		wreg:          1'b0,
		link_addr:     '0,
		in_delay_slot: 1'b0
	};

endpackage

`default_nettype wire

// ==== source/inst_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module inst_decoder import id_pkg::*; (
	input  word_t   inst_i,
	output decode_t dec_o
);

	opcode_e   opcode;
	funct_e    funct;
	reg_addr_t rs;
	reg_addr_t rt;
	reg_addr_t rd;
	logic [4:0]  sa;
	logic [15:0] imm16;
	logic [25:0] index;
	word_t     zimm;
	word_t     simm;
	logic      shift_imm;
	logic      special_ok;

	assign opcode = opcode_e'(inst_i[31:26]);
	assign rs     = inst_i[25:21];
	assign rt     = inst_i[20:16];
	assign rd     = inst_i[15:11];
	assign sa     = inst_i[10:6];
	assign funct  = funct_e'(inst_i[5:0]);
	assign imm16  = inst_i[15:0];
	assign index  = inst_i[25:0];

	assign zimm = {16'h0000, imm16};
	assign simm = {{16{imm16[15]}}, imm16};

	// Shift-by-amount forms need rs clear, every other special form needs sa clear.
	assign shift_imm  = (funct == fn_sll) || (funct == fn_srl) || (funct == fn_sra);
	assign special_ok = shift_imm ? (rs == zero_reg_c) : (sa == 5'd0);

	// ####################################################################
	// Row helpers

	// Register form, both sources read, result to rd.
	function automatic decode_t r_row(decode_t d, alu_op_e op, alu_sel_e sel);
		d.alu_op  = op;
		d.alu_sel = sel;
		d.wreg    = 1'b1;
		d.rd_a    = 1'b1;
		d.rd_b    = 1'b1;
		return d;
	endfunction

	// Immediate form, rs read, immediate in operand b, result to rt.
	function automatic decode_t i_row(decode_t d, alu_op_e op, alu_sel_e sel, word_t imm);
		d.alu_op  = op;
		d.alu_sel = sel;
		d.wreg    = 1'b1;
		d.rd_a    = 1'b1;
		d.wd      = d.addr_b;
		d.imm     = imm;
		return d;
	endfunction

	// Shift by amount, rt read in operand b, amount in operand a.
	function automatic decode_t sa_row(decode_t d, alu_op_e op, logic [4:0] amount);
		d.alu_op  = op;
		d.alu_sel = res_shift;
		d.wreg    = 1'b1;
		d.rd_b    = 1'b1;
		d.imm     = {27'd0, amount};
		return d;
	endfunction

	function automatic decode_t b_row(decode_t d, alu_op_e op, branch_kind_e kind,
					  logic read_b, word_t offset);
		d.alu_op      = op;
		d.alu_sel     = res_jump_branch;
		d.rd_a        = 1'b1;
		d.rd_b        = read_b;
		d.imm         = offset;
		d.branch_kind = kind;
		return d;
	endfunction

	// ####################################################################
	// Decode table

	always_comb begin
		dec_o = '{
			alu_op:      exe_nop_op,
			alu_sel:     res_nop,
			wd:          rd,
			wreg:        1'b0,
			rd_a:        1'b0,
			rd_b:        1'b0,
			addr_a:      rs,
			addr_b:      rt,
			imm:         '0,
			branch_kind: br_none
		};
		case (opcode)
			op_special: begin
				if (special_ok) begin
					case (funct)
						fn_sll:  dec_o = sa_row(dec_o, exe_sll_op, sa);
						fn_srl:  dec_o = sa_row(dec_o, exe_srl_op, sa);
						fn_sra:  dec_o = sa_row(dec_o, exe_sra_op, sa);
						fn_sllv: dec_o = r_row(dec_o, exe_sll_op, res_shift);
						fn_and:  dec_o = r_row(dec_o, exe_and_op, res_logic);
						fn_or:   dec_o = r_row(dec_o, exe_or_op, res_logic);
						fn_nor:  dec_o = r_row(dec_o, exe_nor_op, res_logic);
						fn_add:  dec_o = r_row(dec_o, exe_add_op, res_arith);
						fn_addu: dec_o = r_row(dec_o, exe_addu_op, res_arith);
						fn_sub:  dec_o = r_row(dec_o, exe_sub_op, res_arith);
						fn_subu: dec_o = r_row(dec_o, exe_subu_op, res_arith);
						fn_slt:  dec_o = r_row(dec_o, exe_slt_op, res_arith);
						fn_sltu: dec_o = r_row(dec_o, exe_sltu_op, res_arith);
						// The write enable is qualified later against operand b.
						fn_movn: dec_o = r_row(dec_o, exe_movn_op, res_move);
						fn_movz: dec_o = r_row(dec_o, exe_movz_op, res_move);
						fn_jr: begin
							dec_o.alu_op      = exe_jr_op;
							dec_o.alu_sel     = res_jump_branch;
							dec_o.rd_a        = 1'b1;
							dec_o.branch_kind = br_jr;
						end
						default: ;
					endcase
				end
			end
			op_ori:   dec_o = i_row(dec_o, exe_or_op, res_logic, zimm);
			op_andi:  dec_o = i_row(dec_o, exe_and_op, res_logic, zimm);
			op_addi:  dec_o = i_row(dec_o, exe_addi_op, res_arith, simm);
			op_addiu: dec_o = i_row(dec_o, exe_addiu_op, res_arith, simm);
			op_slti:  dec_o = i_row(dec_o, exe_slt_op, res_arith, simm);
			op_sltiu: dec_o = i_row(dec_o, exe_sltu_op, res_arith, simm);
			op_lw:    dec_o = i_row(dec_o, exe_lw_op, res_load_store, simm);
			op_sw: begin
				dec_o      = r_row(dec_o, exe_sw_op, res_load_store);
				dec_o.wreg = 1'b0;
				dec_o.imm  = simm;
			end
			op_j, op_jal: begin
				dec_o.alu_op      = (opcode == op_jal) ? exe_jal_op : exe_j_op;
				dec_o.alu_sel     = res_jump_branch;
				dec_o.imm         = {6'd0, index};
				dec_o.branch_kind = (opcode == op_jal) ? br_jal : br_j;
				if (opcode == op_jal) begin
					dec_o.wreg = 1'b1;
					dec_o.wd   = link_reg_c;
				end
			end
			op_beq:  dec_o = b_row(dec_o, exe_beq_op, br_beq, 1'b1, simm);
			op_bne:  dec_o = b_row(dec_o, exe_bne_op, br_bne, 1'b1, simm);
			op_bgtz: dec_o = b_row(dec_o, exe_bgtz_op, br_bgtz, 1'b0, simm);
			default: ;
		endcase
	end

	always_comb begin
		assert final (dec_o.branch_kind == br_none || dec_o.alu_sel == res_jump_branch)
		else $error("branch decoded outside the jump/branch class");
	end

endmodule

`default_nettype wire

// ==== source/operand_forward.sv ====
`timescale 1ns/1ps
`default_nettype none

module operand_forward import id_pkg::*; (
	input  logic      rd_i,
	input  reg_addr_t addr_i,
	input  word_t     imm_i,
	input  word_t     rf_data_i,
	input  bypass_t   ex_fwd_i,
	input  bypass_t   mem_fwd_i,
	input  id_ex_t    ex_inst_i,
	output word_t     operand_o,
	output logic      load_use_o
);

	logic nonzero;
	logic ex_load_hit;
	logic ex_hit;
	logic mem_hit;

	assign nonzero = (addr_i != zero_reg_c);

	// A load in execute has no data yet, so its destination cannot be bypassed.
	assign ex_load_hit = nonzero && (ex_inst_i.alu_op == exe_lw_op) && (ex_inst_i.wd == addr_i);
	assign ex_hit      = nonzero && ex_fwd_i.wreg && (ex_fwd_i.wd == addr_i);
	assign mem_hit     = nonzero && mem_fwd_i.wreg && (mem_fwd_i.wd == addr_i);

	always_comb begin
		load_use_o = 1'b0;
		operand_o  = imm_i;
		if (rd_i) begin
			if (ex_load_hit) begin
				load_use_o = 1'b1;
				operand_o  = rf_data_i;
			end else if (ex_hit) begin
				operand_o = ex_fwd_i.wdata;
			end else if (mem_hit) begin
				operand_o = mem_fwd_i.wdata;
			end else begin
				operand_o = rf_data_i;
			end
		end
	end

	always_comb begin
		assert final (!load_use_o || rd_i)
		else $error("load-use hazard flagged on an operand that is not read");
	end

endmodule

`default_nettype wire

// ==== source/branch_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module branch_unit import id_pkg::*; (
	input  word_t   pc_i,
	input  decode_t dec_i,
	input  word_t   op_a_i,
	input  word_t   op_b_i,
	output branch_t branch_o
);

	word_t pc_plus_4;
	word_t pc_plus_8;
	word_t jump_target;
	word_t branch_target;
	logic  a_positive;

	assign pc_plus_4 = pc_i + 32'd4;
	assign pc_plus_8 = pc_i + 32'd8;

	// The decoder already sign-extended the offset into imm.
	assign jump_target   = {pc_plus_4[31:28], dec_i.imm[25:0], 2'b00};
	assign branch_target = pc_plus_4 + {dec_i.imm[29:0], 2'b00};

	assign a_positive = !op_a_i[31] && (op_a_i != '0);

	always_comb begin
		branch_o.taken     = 1'b0;
		branch_o.target    = '0;
		branch_o.link_addr = '0;
		case (dec_i.branch_kind)
			br_j: begin
				branch_o.taken  = 1'b1;
				branch_o.target = jump_target;
			end
			br_jal: begin
				branch_o.taken     = 1'b1;
				branch_o.target    = jump_target;
				branch_o.link_addr = pc_plus_8;
			end
			br_jr: begin
				branch_o.taken  = 1'b1;
				branch_o.target = op_a_i;
			end
			br_beq: begin
				branch_o.taken  = (op_a_i == op_b_i);
				branch_o.target = branch_target;
			end
			br_bne: begin
				branch_o.taken  = (op_a_i != op_b_i);
				branch_o.target = branch_target;
			end
			br_bgtz: begin
				branch_o.taken  = a_positive;
				branch_o.target = branch_target;
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

// ==== source/id_ex_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

module id_ex_reg import id_pkg::*; (
	input  logic    clk,
	input  logic    arst_n_i,
	input  logic    flush_i,
	input  logic    stall_i,
	input  decode_t dec_i,
	input  word_t   op_a_i,
	input  word_t   op_b_i,
	input  branch_t br_i,
	output id_ex_t  id_ex_o
);

	logic   wreg_commit;
	logic   delay_slot_q;
	id_ex_t id_ex_d;
	id_ex_t id_ex_q;

	// Conditional moves only write back when the test on rt holds.
	always_comb begin
		case (dec_i.alu_op)
			exe_movn_op: wreg_commit = dec_i.wreg && (op_b_i != '0);
			exe_movz_op: wreg_commit = dec_i.wreg && (op_b_i == '0);
			default:     wreg_commit = dec_i.wreg;
		endcase
	end

	always_comb begin
		id_ex_d = '{
			alu_op:        dec_i.alu_op,
			alu_sel:       dec_i.alu_sel,
			op_a:          op_a_i,
			op_b:          op_b_i,
			wd:            dec_i.wd,
			wreg:          wreg_commit,
			link_addr:     br_i.link_addr,
			in_delay_slot: delay_slot_q
		};
	end

	// ####################################################################
	// Stage register and delay-slot flag

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			id_ex_q      <= id_ex_bubble_c;
			delay_slot_q <= 1'b0;
		end else if (flush_i) begin
			id_ex_q      <= id_ex_bubble_c;
			delay_slot_q <= 1'b0;
		end else if (stall_i) begin
			// The held instruction comes back next cycle, keep its slot flag.
			id_ex_q <= id_ex_bubble_c;
		end else begin
			id_ex_q      <= id_ex_d;
			delay_slot_q <= br_i.taken;
		end
	end

	assign id_ex_o = id_ex_q;

	assert property (@(posedge clk) disable iff (!arst_n_i) stall_i |=> !id_ex_o.wreg)
	else $error("stage register wrote back after a stall");

endmodule

`default_nettype wire

// ==== source/decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_stage import id_pkg::*; (
	input  logic    clk,
	input  logic    arst_n_i,
	input  logic    flush_i,
	input  word_t   pc_i,
	input  word_t   inst_i,
	input  word_t   rf_data_a_i,
	input  word_t   rf_data_b_i,
	input  bypass_t ex_fwd_i,
	input  bypass_t mem_fwd_i,
	output rf_req_t rf_req_o,
	output branch_t branch_o,
	output logic    stall_o,
	output id_ex_t  id_ex_o
);

	decode_t dec;
	word_t   op_a;
	word_t   op_b;
	logic    load_use_a;
	logic    load_use_b;
	branch_t br;
	id_ex_t  id_ex;

	inst_decoder u_dec (
		.inst_i (inst_i),
		.dec_o  (dec)
	);

	// The register file answers in the same cycle.
	assign rf_req_o = '{
		re_a:   dec.rd_a,
		re_b:   dec.rd_b,
		addr_a: dec.addr_a,
		addr_b: dec.addr_b
	};

	// ####################################################################
	// Operand selection

	operand_forward u_fwd_a (
		.rd_i       (dec.rd_a),
		.addr_i     (dec.addr_a),
		.imm_i      (dec.imm),
		.rf_data_i  (rf_data_a_i),
		.ex_fwd_i   (ex_fwd_i),
		.mem_fwd_i  (mem_fwd_i),
		.ex_inst_i  (id_ex),
		.operand_o  (op_a),
		.load_use_o (load_use_a)
	);

	operand_forward u_fwd_b (
		.rd_i       (dec.rd_b),
		.addr_i     (dec.addr_b),
		.imm_i      (dec.imm),
		.rf_data_i  (rf_data_b_i),
		.ex_fwd_i   (ex_fwd_i),
		.mem_fwd_i  (mem_fwd_i),
		.ex_inst_i  (id_ex),
		.operand_o  (op_b),
		.load_use_o (load_use_b)
	);

	assign stall_o = load_use_a | load_use_b;

	branch_unit u_branch (
		.pc_i     (pc_i),
		.dec_i    (dec),
		.op_a_i   (op_a),
		.op_b_i   (op_b),
		.branch_o (br)
	);

	assign branch_o = br;

	id_ex_reg u_id_ex (
		.clk      (clk),
		.arst_n_i (arst_n_i),
		.flush_i  (flush_i),
		.stall_i  (stall_o),
		.dec_i    (dec),
		.op_a_i   (op_a),
		.op_b_i   (op_b),
		.br_i     (br),
		.id_ex_o  (id_ex)
	);

	assign id_ex_o = id_ex;

endmodule

`default_nettype wire

// ==== tests/tb_checks.svh ====
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// ######################################################################
// Compare tasks, one per kind of result

task automatic check_id_ex(input string name, input id_ex_t exp, input id_ex_t act);
	check_count++;
	if (act !== exp) begin
		err_count++;
		$display("[FAIL] %s: id_ex expected %h, actual %h", name, exp, act);
		$display("       op %s/%s wd %0d wreg %b ds %b, got op %s/%s wd %0d wreg %b ds %b",
			exp.alu_op.name(), exp.alu_sel.name(), exp.wd, exp.wreg, exp.in_delay_slot,
			act.alu_op.name(), act.alu_sel.name(), act.wd, act.wreg, act.in_delay_slot);
	end
endtask

task automatic check_branch(input string name, input branch_t exp, input branch_t act);
	check_count++;
	if (act !== exp) begin
		err_count++;
		$display("[FAIL] %s: branch expected taken %b target %h link %h, actual %b %h %h",
			name, exp.taken, exp.target, exp.link_addr,
			act.taken, act.target, act.link_addr);
	end
endtask

// An address only matters when its read enable is set.
task automatic check_rf_req(input string name, input rf_req_t exp, input rf_req_t act);
	check_count++;
	if (act.re_a !== exp.re_a || act.re_b !== exp.re_b ||
	    (exp.re_a && act.addr_a !== exp.addr_a) ||
	    (exp.re_b && act.addr_b !== exp.addr_b)) begin
		err_count++;
		$display("[FAIL] %s: rf_req expected re %b%b addr %0d %0d, actual re %b%b addr %0d %0d",
			name, exp.re_a, exp.re_b, exp.addr_a, exp.addr_b,
			act.re_a, act.re_b, act.addr_a, act.addr_b);
	end
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
	check_count++;
	if (act !== exp) begin
		err_count++;
		$display("[FAIL] %s: expected %b, actual %b", name, exp, act);
	end
endtask

// Prints the closing line of one test.
task automatic report_test(input string name, input int errs_at_start);
	if (err_count == errs_at_start)
		$display("%-12s ok", name);
	else
		$display("%-12s %0d errors", name, err_count - errs_at_start);
endtask

`endif

// ==== tests/tb_decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_decode_stage import id_pkg::*; ();

	localparam word_t idle_word = 32'hfc00_0000;
	localparam word_t base_pc   = 32'h0040_1000;

	logic    clk;
	logic    arst_n;
	logic    flush;
	word_t   pc;
	word_t   inst;
	word_t   rf_data_a;
	word_t   rf_data_b;
	bypass_t ex_fwd;
	bypass_t mem_fwd;
	rf_req_t rf_req;
	branch_t branch;
	logic    stall;
	id_ex_t  id_ex;

	int          err_count = 0;
	int          check_count = 0;
	logic [31:0] rnd_state = 32'ha163_2446;

	`include "tb_checks.svh"

	decode_stage i_dut (
		.clk         (clk),
		.arst_n_i    (arst_n),
		.flush_i     (flush),
		.pc_i        (pc),
		.inst_i      (inst),
		.rf_data_a_i (rf_data_a),
		.rf_data_b_i (rf_data_b),
		.ex_fwd_i    (ex_fwd),
		.mem_fwd_i   (mem_fwd),
		.rf_req_o    (rf_req),
		.branch_o    (branch),
		.stall_o     (stall),
		.id_ex_o     (id_ex)
	);

	always #2 clk = ~clk;

	// Register file model, answers in the same cycle.
	function automatic word_t rf_val(input reg_addr_t n);
		return word_t'(n) * 32'h0101_0101;
	endfunction

	assign rf_data_a = rf_val(rf_req.addr_a);
	assign rf_data_b = rf_val(rf_req.addr_b);

	// ######################################################################
	// Helpers

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] next_rand();
		rnd_state = xorshift(rnd_state);
		return rnd_state;
	endfunction

	function automatic word_t enc_r(input funct_e f, input reg_addr_t rs, input reg_addr_t rt,
					input reg_addr_t rd, input logic [4:0] sa);
		return {6'b000000, rs, rt, rd, sa, f};
	endfunction

	function automatic word_t enc_i(input opcode_e op, input reg_addr_t rs, input reg_addr_t rt,
					input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic id_ex_t exp_word(input alu_op_e op, input alu_sel_e sel, input word_t a,
					    input word_t b, input reg_addr_t wd, input logic wreg,
					    input word_t link, input logic ds);
		id_ex_t e;
		e.alu_op        = op;
		e.alu_sel       = sel;
		e.op_a          = a;
		e.op_b          = b;
		e.wd            = wd;
		e.wreg          = wreg;
		e.link_addr     = link;
		e.in_delay_slot = ds;
		return e;
	endfunction

	function automatic id_ex_t bubble();
		return exp_word(exe_nop_op, res_nop, '0, '0, '0, 1'b0, '0, 1'b0);
	endfunction

	function automatic word_t br_target(input logic [15:0] off);
		return base_pc + 32'd4 + {{14{off[15]}}, off, 2'b00};
	endfunction

	// Jumps keep the region of the word after the jump.
	function automatic word_t jump_dest(input logic [25:0] index);
		word_t pc4;
		pc4 = base_pc + 32'd4;
		return {pc4[31:28], index, 2'b00};
	endfunction

	function automatic branch_t exp_br(input logic taken, input word_t target, input word_t link);
		branch_t b;
		b.taken     = taken;
		b.target    = target;
		b.link_addr = link;
		return b;
	endfunction

	// Called on a falling edge; the short delay lets combinational outputs settle.
	task automatic issue(input word_t w);
		inst = w;
		#1;
	endtask

	task automatic advance();
		@(negedge clk);
	endtask

	task automatic fwd_idle();
		ex_fwd  = '{wreg: 1'b0, wd: '0, wdata: '0};
		mem_fwd = '{wreg: 1'b0, wd: '0, wdata: '0};
	endtask

	// ######################################################################
	// Tests

	task automatic test_reset_flush();
		int start;
		start = err_count;
		check_id_ex("reset", bubble(), id_ex);
		issue(enc_i(op_ori, 5'd1, 5'd2, 16'h1234));
		flush = 1'b1;
		advance();
		flush = 1'b0;
		check_id_ex("flush", bubble(), id_ex);
		issue(idle_word);
		advance();
		report_test("reset_flush", start);
	endtask

	task automatic test_decode();
		int start;
		logic [31:0] r;
		reg_addr_t rs, rt, rd;
		logic [4:0] sa;
		logic [15:0] imm;
		word_t w;
		id_ex_t e;
		rf_req_t q;
		word_t sx;
		start = err_count;
		for (int i = 0; i < 30; i++) begin
			r   = next_rand();
			rs  = r[4:0];
			rt  = r[9:5];
			rd  = r[14:10];
			sa  = r[19:15];
			imm = r[31:16];
			sx  = {{16{imm[15]}}, imm};
			q   = '{re_a: 1'b1, re_b: 1'b1, addr_a: rs, addr_b: rt};
			case (next_rand() % 13)
				0: begin
					w = enc_i(op_ori, rs, rt, imm);
					e = exp_word(exe_or_op, res_logic, rf_val(rs), {16'h0, imm}, rt, 1, 0, 0);
					q.re_b = 1'b0;
				end
				1: begin
					w = enc_i(op_andi, rs, rt, imm);
					e = exp_word(exe_and_op, res_logic, rf_val(rs), {16'h0, imm}, rt, 1, 0, 0);
					q.re_b = 1'b0;
				end
				2: begin
					w = enc_i(op_addi, rs, rt, imm);
					e = exp_word(exe_addi_op, res_arith, rf_val(rs), sx, rt, 1, 0, 0);
					q.re_b = 1'b0;
				end
				3: begin
					w = enc_i(op_slti, rs, rt, imm);
					e = exp_word(exe_slt_op, res_arith, rf_val(rs), sx, rt, 1, 0, 0);
					q.re_b = 1'b0;
				end
				4: begin
					w = enc_i(op_lw, rs, rt, imm);
					e = exp_word(exe_lw_op, res_load_store, rf_val(rs), sx, rt, 1, 0, 0);
					q.re_b = 1'b0;
				end
				5: begin
					// Store reads both registers and writes nothing.
					w = enc_i(op_sw, rs, rt, imm);
					e = exp_word(exe_sw_op, res_load_store, rf_val(rs), rf_val(rt),
						imm[15:11], 0, 0, 0);
				end
				6: begin
					w = enc_r(fn_sll, 5'd0, rt, rd, sa);
					e = exp_word(exe_sll_op, res_shift, {27'd0, sa}, rf_val(rt), rd, 1, 0, 0);
					q.re_a = 1'b0;
				end
				7: begin
					w = enc_r(fn_srl, 5'd0, rt, rd, sa);
					e = exp_word(exe_srl_op, res_shift, {27'd0, sa}, rf_val(rt), rd, 1, 0, 0);
					q.re_a = 1'b0;
				end
				8: begin
					w = enc_r(fn_sllv, rs, rt, rd, 5'd0);
					e = exp_word(exe_sll_op, res_shift, rf_val(rs), rf_val(rt), rd, 1, 0, 0);
				end
				9: begin
					w = enc_r(fn_add, rs, rt, rd, 5'd0);
					e = exp_word(exe_add_op, res_arith, rf_val(rs), rf_val(rt), rd, 1, 0, 0);
				end
				10: begin
					w = enc_r(fn_sub, rs, rt, rd, 5'd0);
					e = exp_word(exe_sub_op, res_arith, rf_val(rs), rf_val(rt), rd, 1, 0, 0);
				end
				11: begin
					w = enc_r(fn_sltu, rs, rt, rd, 5'd0);
					e = exp_word(exe_sltu_op, res_arith, rf_val(rs), rf_val(rt), rd, 1, 0, 0);
				end
				default: begin
					w = enc_r(fn_nor, rs, rt, rd, 5'd0);
					e = exp_word(exe_nor_op, res_logic, rf_val(rs), rf_val(rt), rd, 1, 0, 0);
				end
			endcase
			issue(w);
			check_rf_req("decode", q, rf_req);
			advance();
			check_id_ex("decode", e, id_ex);
			// An idle word keeps a random load from stalling the next word.
			issue(idle_word);
			advance();
		end
		report_test("decode", start);
	endtask

	task automatic test_forward();
		int start;
		start = err_count;
		ex_fwd  = '{wreg: 1'b1, wd: 5'd5, wdata: 32'hdead_0001};
		mem_fwd = '{wreg: 1'b1, wd: 5'd5, wdata: 32'hbeef_0002};
		issue(enc_r(fn_add, 5'd5, 5'd7, 5'd9, 5'd0));
		advance();
		check_id_ex("forward",
			exp_word(exe_add_op, res_arith, 32'hdead_0001, rf_val(7), 9, 1, 0, 0), id_ex);
		mem_fwd.wd = 5'd7;
		issue(enc_r(fn_add, 5'd5, 5'd7, 5'd9, 5'd0));
		advance();
		check_id_ex("forward",
			exp_word(exe_add_op, res_arith, 32'hdead_0001, 32'hbeef_0002, 9, 1, 0, 0), id_ex);
		ex_fwd.wd  = 5'd0;
		mem_fwd.wd = 5'd0;
		issue(enc_r(fn_or, 5'd0, 5'd3, 5'd4, 5'd0));
		advance();
		check_id_ex("forward",
			exp_word(exe_or_op, res_logic, 32'd0, rf_val(3), 4, 1, 0, 0), id_ex);
		fwd_idle();
		issue(idle_word);
		advance();
		report_test("forward", start);
	endtask

	task automatic test_load_use();
		int start;
		int cycles;
		start = err_count;
		issue(enc_i(op_lw, 5'd3, 5'd9, 16'h0004));
		check_bit("load_use", 1'b0, stall);
		advance();
		check_id_ex("load_use",
			exp_word(exe_lw_op, res_load_store, rf_val(3), 32'd4, 9, 1, 0, 0), id_ex);
		issue(enc_r(fn_add, 5'd9, 5'd2, 5'd10, 5'd0));
		check_bit("load_use", 1'b1, stall);
		advance();
		check_id_ex("load_use", bubble(), id_ex);
		cycles = 0;
		while (stall && cycles < 8) begin
			advance();
			cycles++;
		end
		if (stall) begin
			err_count++;
			$display("load_use: stall did not clear within 8 cycles");
		end
		advance();
		check_id_ex("load_use",
			exp_word(exe_add_op, res_arith, rf_val(9), rf_val(2), 10, 1, 0, 0), id_ex);
		issue(idle_word);
		advance();
		report_test("load_use", start);
	endtask

	task automatic test_branch();
		int start;
		start = err_count;
		issue(enc_i(op_beq, 5'd4, 5'd4, 16'hfff0));
		check_branch("branch", exp_br(1, br_target(16'hfff0), 0), branch);
		advance();
		issue(enc_i(op_beq, 5'd4, 5'd5, 16'h0010));
		check_branch("branch", exp_br(0, br_target(16'h0010), 0), branch);
		advance();
		issue(enc_i(op_bne, 5'd4, 5'd5, 16'h0020));
		check_branch("branch", exp_br(1, br_target(16'h0020), 0), branch);
		advance();
		issue(enc_i(op_bne, 5'd6, 5'd6, 16'h8000));
		check_branch("branch", exp_br(0, br_target(16'h8000), 0), branch);
		advance();
		issue(enc_i(op_bgtz, 5'd3, 5'd0, 16'h0003));
		check_branch("branch", exp_br(1, br_target(16'h0003), 0), branch);
		advance();
		issue(enc_i(op_bgtz, 5'd0, 5'd0, 16'h0003));
		check_branch("branch", exp_br(0, br_target(16'h0003), 0), branch);
		advance();
		// A negative operand arrives through the execute bypass.
		ex_fwd = '{wreg: 1'b1, wd: 5'd3, wdata: 32'h8000_0000};
		issue(enc_i(op_bgtz, 5'd3, 5'd0, 16'h0003));
		check_branch("branch", exp_br(0, br_target(16'h0003), 0), branch);
		advance();
		fwd_idle();
		issue({op_j, 26'h012_3456});
		check_branch("branch", exp_br(1, jump_dest(26'h012_3456), 0), branch);
		advance();
		issue(enc_r(fn_jr, 5'd6, 5'd0, 5'd0, 5'd0));
		check_branch("branch", exp_br(1, rf_val(6), 0), branch);
		advance();
		issue(idle_word);
		advance();
		issue({op_jal, 26'h000_0040});
		check_branch("branch",
			exp_br(1, jump_dest(26'h000_0040), base_pc + 32'd8), branch);
		advance();
		check_id_ex("branch", exp_word(exe_jal_op, res_jump_branch, 32'h40, 32'h40,
			link_reg_c, 1, base_pc + 32'd8, 0), id_ex);
		issue(idle_word);
		advance();
		issue(idle_word);
		advance();
		report_test("branch", start);
	endtask

	task automatic test_slot_move();
		int start;
		start = err_count;
		issue(enc_i(op_beq, 5'd4, 5'd4, 16'h0008));
		advance();
		issue(enc_i(op_ori, 5'd1, 5'd2, 16'h00ff));
		advance();
		check_id_ex("slot_move",
			exp_word(exe_or_op, res_logic, rf_val(1), 32'hff, 2, 1, 0, 1), id_ex);
		issue(enc_r(fn_movn, 5'd2, 5'd0, 5'd8, 5'd0));
		advance();
		check_id_ex("slot_move",
			exp_word(exe_movn_op, res_move, rf_val(2), 32'd0, 8, 0, 0, 0), id_ex);
		issue(enc_r(fn_movn, 5'd2, 5'd3, 5'd8, 5'd0));
		advance();
		check_id_ex("slot_move",
			exp_word(exe_movn_op, res_move, rf_val(2), rf_val(3), 8, 1, 0, 0), id_ex);
		issue(enc_r(fn_movz, 5'd2, 5'd0, 5'd8, 5'd0));
		advance();
		check_id_ex("slot_move",
			exp_word(exe_movz_op, res_move, rf_val(2), 32'd0, 8, 1, 0, 0), id_ex);
		issue(enc_r(fn_movz, 5'd2, 5'd3, 5'd8, 5'd0));
		advance();
		check_id_ex("slot_move",
			exp_word(exe_movz_op, res_move, rf_val(2), rf_val(3), 8, 0, 0, 0), id_ex);
		issue(idle_word);
		advance();
		report_test("slot_move", start);
	endtask

	// ######################################################################
	// Sequence

	initial begin
		clk    = 1'b0;
		arst_n = 1'b0;
		flush  = 1'b0;
		pc     = base_pc;
		inst   = idle_word;
		fwd_idle();
		repeat (8) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;
		#1;
		test_reset_flush();
		test_decode();
		test_forward();
		test_load_use();
		test_branch();
		test_slot_move();
		$display("checks %0d, errors %0d", check_count, err_count);
		if (err_count == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

	// Whole-run limit in case the sequence never completes.
	initial begin
		#100000;
		$display("simulation did not complete within the time limit");
		$display("Done: errors found");
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+tests
source/id_pkg.sv
source/inst_decoder.sv
source/operand_forward.sv
source/branch_unit.sv
source/id_ex_reg.sv
source/decode_stage.sv
tests/tb_decode_stage.sv

// ==== Bender.yml ====
package:
  name: decode_stage

sources:
  - target: rtl
    files:
      - source/id_pkg.sv
      - source/inst_decoder.sv
      - source/operand_forward.sv
      - source/branch_unit.sv
      - source/id_ex_reg.sv
      - source/decode_stage.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_decode_stage.sv
